//--- logic/bp_settings.svh
// sizing macros and register offsets for the perceptron branch predictor
`ifndef BP_SETTINGS_SVH
`define BP_SETTINGS_SVH

// ==============================
// predictor geometry
// ==============================
// history bits and weights per row are the same number
`define BP_HIST_LEN     16
// signed weight width
`define BP_WEIGHT_W     8
// rows in the weight table
`define BP_ROWS         256
// branch address width
`define BP_ADDR_W       32
// commit records buffered ahead of training
`define BP_QUEUE_DEPTH  8

// ==============================
// apb register byte offsets
// ==============================
`define BP_REG_CTRL     8'h00
`define BP_REG_COMMITS  8'h04
`define BP_REG_MISPRED  8'h08
`define BP_REG_HISTORY  8'h0C
`define BP_REG_STATUS   8'h10

`endif

//--- logic/bp_pkg.sv
// predictor vector types, commit and apb structs, row hash and weight access functions
`include "bp_settings.svh"

package bp_pkg;

	// ==============================
	// plain vector types
	// ==============================
	typedef logic [`BP_ADDR_W-1:0] pc_t;
	typedef logic [$clog2(`BP_ROWS)-1:0] row_idx_t;
	typedef logic signed [`BP_WEIGHT_W-1:0] weight_t;
	// weight i sits at slice i
	typedef logic [`BP_HIST_LEN*`BP_WEIGHT_W-1:0] weight_row_t;
	// bit 0 is the newest outcome
	typedef logic [`BP_HIST_LEN-1:0] hist_t;
	// wide enough for HIST_LEN weights of either sign
	typedef logic signed [`BP_WEIGHT_W+$clog2(`BP_HIST_LEN):0] sum_t;
	typedef logic [$clog2(`BP_QUEUE_DEPTH):0] q_level_t;
	typedef logic [7:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;

	// ==============================
	// structs
	// ==============================
	typedef struct packed {
		pc_t pc;
		logic taken;
		logic predicted;
	} commit_t;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		apb_addr_t paddr;
		apb_data_t pwdata;
	} apb_req_t;

	typedef struct packed {
		apb_data_t prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

	// xor of the four address bytes picks the table row
	function automatic row_idx_t fold_pc(pc_t pc);
		return pc[7:0] ^ pc[15:8] ^ pc[23:16] ^ pc[31:24];
	endfunction

	// pull weight i out of a packed row as a signed value
	function automatic weight_t row_weight(weight_row_t row, int i);
		return weight_t'(row[i*`BP_WEIGHT_W +: `BP_WEIGHT_W]);
	endfunction

endpackage

//--- logic/perceptron_ram.sv
// perceptron weight table with one write port, two async read ports and a reset wipe
`timescale 1ns/100ps
`include "bp_settings.svh"

module perceptron_ram import bp_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        we,
	input  row_idx_t    waddr,
	input  weight_row_t wdata,
	input  row_idx_t    raddr_a,
	output weight_row_t rdata_a,
	input  row_idx_t    raddr_b,
	output weight_row_t rdata_b
);

	weight_row_t mem [`BP_ROWS];

	// wipe sweep state
	row_idx_t wipe_idx;
	logic wiping;

	// ==============================
	// reset sweep
	// ==============================
	// one row cleared per cycle after reset drops
	always_ff @(posedge clk) begin
		if (rst) begin
			wipe_idx <= '0;
			wiping <= 1'b1;
		end else if (wiping) begin
			wipe_idx <= wipe_idx + row_idx_t'(1);
			// last row reached
			if (wipe_idx == row_idx_t'(`BP_ROWS - 1))
				wiping <= 1'b0;
		end
	end

	// sweep owns the write port until it finishes
	always_ff @(posedge clk) begin
		if (wiping)
			mem[wipe_idx] <= '0;
		else if (we)
			mem[waddr] <= wdata;
	end

	// port a for lookups, port b for training
	assign rdata_a = mem[raddr_a];
	assign rdata_b = mem[raddr_b];

endmodule

//--- logic/commit_queue.sv
// circular FIFO of commit records with ready back-pressure, pop gate and level output
`timescale 1ns/100ps
`include "bp_settings.svh"

module commit_queue import bp_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     push_valid,
	input  commit_t  push_data,
	output logic     push_ready,
	input  logic     pop_en,
	output logic     pop_valid,
	output commit_t  pop_data,
	output q_level_t level
);

	localparam int PTR_W = $clog2(`BP_QUEUE_DEPTH);
	localparam logic [PTR_W-1:0] LAST = PTR_W'(`BP_QUEUE_DEPTH - 1);

	commit_t mem [`BP_QUEUE_DEPTH];

	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] tail;
	q_level_t count;
	logic push;

	// ==============================
	// handshakes
	// ==============================
	// only a full queue refuses a record
	assign push_ready = (count != q_level_t'(`BP_QUEUE_DEPTH));
	assign push = push_valid & push_ready;
	// drain whenever training is on and something is waiting
	assign pop_valid = pop_en & (count != '0);
	assign pop_data = mem[head];
	assign level = count;

	// record storage
	always_ff @(posedge clk) begin
		if (push)
			mem[tail] <= push_data;
	end

	// ==============================
	// pointers and count
	// ==============================
	always_ff @(posedge clk) begin
		if (rst) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (push)
				tail <= (tail == LAST) ? '0 : tail + 1'b1;
			if (pop_valid)
				head <= (head == LAST) ? '0 : head + 1'b1;
			// simultaneous push and pop leaves the count alone
			if (push && !pop_valid)
				count <= count + q_level_t'(1);
			else if (!push && pop_valid)
				count <= count - q_level_t'(1);
		end
	end

endmodule

//--- logic/perceptron_dot.sv
// lookup pipeline with address fold, partial dot-product sums and sign prediction
`timescale 1ns/100ps
`include "bp_settings.svh"

module perceptron_dot import bp_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        lookup_valid,
	input  pc_t         lookup_pc,
	input  hist_t       history,
	output row_idx_t    row_idx,
	input  weight_row_t row,
	output logic        pred_valid,
	output logic        pred_taken
);

	// four partial sums of four weights each
	localparam int N_PART = 4;
	localparam int PART_LEN = `BP_HIST_LEN / N_PART;

	sum_t part [N_PART];
	sum_t part_q [N_PART];
	logic s1_valid;
	sum_t total;

	// ==============================
	// stage 0
	// ==============================
	// row comes straight back from ram port a
	assign row_idx = fold_pc(lookup_pc);

	// add weight where history says taken, subtract otherwise
	always_comb begin
		for (int p = 0; p < N_PART; p++) begin
			part[p] = '0;
			for (int j = 0; j < PART_LEN; j++) begin
				if (history[p*PART_LEN + j])
					part[p] = part[p] + sum_t'(row_weight(row, p*PART_LEN + j));
				else
					part[p] = part[p] - sum_t'(row_weight(row, p*PART_LEN + j));
			end
		end
	end

	// ==============================
	// stage 1
	// ==============================
	always_ff @(posedge clk) begin
		if (rst)
			s1_valid <= 1'b0;
		else
			s1_valid <= lookup_valid;
	end

	always_ff @(posedge clk) begin
		for (int p = 0; p < N_PART; p++)
			part_q[p] <= part[p];
	end

	// ==============================
	// stage 2
	// ==============================
	always_comb begin
		total = '0;
		for (int p = 0; p < N_PART; p++)
			total = total + part_q[p];
	end

	always_ff @(posedge clk) begin
		if (rst)
			pred_valid <= 1'b0;
		else
			pred_valid <= s1_valid;
	end

	// a sum of zero or more counts as taken, so the sign bit is inverted
	always_ff @(posedge clk)
		pred_taken <= ~total[$bits(sum_t)-1];

endmodule

//--- logic/perceptron_trainer.sv
// global history register and two-stage read-modify-write weight training with forwarding
`timescale 1ns/100ps
`include "bp_settings.svh"

module perceptron_trainer import bp_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        pop_valid,
	input  commit_t     pop_data,
	output hist_t       history,
	output row_idx_t    rd_idx,
	input  weight_row_t rd_row,
	output logic        we,
	output row_idx_t    wr_idx,
	output weight_row_t wr_row,
	output logic        retire,
	output logic        retire_mispredict
);

	localparam weight_t W_MAX = weight_t'((1 << (`BP_WEIGHT_W - 1)) - 1);
	localparam weight_t W_MIN = -W_MAX;
	localparam weight_t W_ONE = weight_t'(1);

	hist_t hist_q;
	commit_t rec_q;
	hist_t snap_q;
	logic s1_valid;
	weight_row_t base_row;
	weight_row_t new_row;

	assign history = hist_q;

	// ==============================
	// pop stage
	// ==============================
	// newest outcome shifts in at bit 0
	always_ff @(posedge clk) begin
		if (rst) begin
			hist_q <= '0;
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= pop_valid;
			if (pop_valid)
				hist_q <= {hist_q[`BP_HIST_LEN-2:0], pop_data.taken};
		end
	end

	// record plus the history it was trained against
	always_ff @(posedge clk) begin
		if (pop_valid) begin
			rec_q <= pop_data;
			snap_q <= hist_q;
		end
	end

	// one pulse per popped record
	assign retire = s1_valid;
	assign retire_mispredict = s1_valid & (rec_q.predicted != rec_q.taken);

	// ==============================
	// read and modify stage
	// ==============================
	assign rd_idx = fold_pc(rec_q.pc);
	// pending write to the same row is newer than the ram copy
	assign base_row = (we && wr_idx == rd_idx) ? wr_row : rd_row;

	// agreement with the history bit pushes the weight up, saturating both ways
	always_comb begin
		weight_t w;
		for (int i = 0; i < `BP_HIST_LEN; i++) begin
			w = row_weight(base_row, i);
			if (rec_q.taken == snap_q[i]) begin
				if (w != W_MAX)
					w = w + W_ONE;
			end else if (w != W_MIN) begin
				w = w - W_ONE;
			end
			new_row[i*`BP_WEIGHT_W +: `BP_WEIGHT_W] = w;
		end
	end

	// ==============================
	// write stage
	// ==============================
	always_ff @(posedge clk) begin
		if (rst)
			we <= 1'b0;
		else
			we <= s1_valid;
	end

	always_ff @(posedge clk) begin
		wr_idx <= rd_idx;
		wr_row <= new_row;
	end

endmodule

//--- logic/bp_apb_regs.sv
// APB register slave with train enable, commit and mispredict counters, history and queue status
`timescale 1ns/100ps
`include "bp_settings.svh"

module bp_apb_regs import bp_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  apb_req_t apb_req,
	output apb_rsp_t apb_rsp,
	input  logic     retire,
	input  logic     retire_mispredict,
	input  hist_t    history,
	input  q_level_t queue_level,
	input  logic     queue_full,
	output logic     train_en
);

	apb_data_t commits;
	apb_data_t mispred;
	logic access;
	logic wr;
	logic mapped;
	apb_data_t rdata;

	// access phase completes the transfer with no wait states
	assign access = apb_req.psel & apb_req.penable;
	assign wr = access & apb_req.pwrite;

	// ==============================
	// control and counters
	// ==============================
	always_ff @(posedge clk) begin
		if (rst) begin
			train_en <= 1'b0;
			commits <= '0;
			mispred <= '0;
		end else begin
			if (wr && apb_req.paddr == `BP_REG_CTRL)
				train_en <= apb_req.pwdata[0];
			// any write clears, a write beats a retire in the same cycle
			if (wr && apb_req.paddr == `BP_REG_COMMITS)
				commits <= '0;
			else if (retire)
				commits <= commits + 1'b1;
			if (wr && apb_req.paddr == `BP_REG_MISPRED)
				mispred <= '0;
			else if (retire_mispredict)
				mispred <= mispred + 1'b1;
		end
	end

	// ==============================
	// read mux
	// ==============================
	always_comb begin
		mapped = 1'b1;
		rdata = '0;
		case (apb_req.paddr)
			`BP_REG_CTRL:    rdata = apb_data_t'(train_en);
			`BP_REG_COMMITS: rdata = commits;
			`BP_REG_MISPRED: rdata = mispred;
			`BP_REG_HISTORY: rdata = apb_data_t'(history);
			// level in the low bits, full just above it
			`BP_REG_STATUS:  rdata = apb_data_t'({queue_full, queue_level});
			default:         mapped = 1'b0;
		endcase
	end

	always_comb begin
		apb_rsp.prdata = rdata;
		apb_rsp.pready = 1'b1;
		apb_rsp.pslverr = access & ~mapped;
	end

endmodule

//--- logic/perceptron_predictor.sv
// perceptron predictor top level wiring table, commit queue, lookup, trainer and registers
`timescale 1ns/100ps
`include "bp_settings.svh"

module perceptron_predictor import bp_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	// lookup side
	input  logic     lookup_valid,
	input  pc_t      lookup_pc,
	output logic     pred_valid,
	output logic     pred_taken,
	// commit side
	input  logic     commit_valid,
	input  commit_t  commit,
	output logic     commit_ready,
	// register bus
	input  apb_req_t apb_req,
	output apb_rsp_t apb_rsp
);

	// ==============================
	// interconnect
	// ==============================
	// lookup read path on ram port a
	row_idx_t look_idx;
	weight_row_t look_row;
	// training read path on ram port b
	row_idx_t train_rd_idx;
	weight_row_t train_rd_row;
	// training write port
	logic train_we;
	row_idx_t train_wr_idx;
	weight_row_t train_wr_row;
	// queue to trainer
	logic pop_valid;
	commit_t pop_data;
	q_level_t queue_level;
	// trainer to lookup and registers
	hist_t history;
	logic retire;
	logic retire_mispredict;
	logic train_en;

	perceptron_ram u_ram (
		.clk     (clk),
		.rst     (rst),
		.we      (train_we),
		.waddr   (train_wr_idx),
		.wdata   (train_wr_row),
		.raddr_a (look_idx),
		.rdata_a (look_row),
		.raddr_b (train_rd_idx),
		.rdata_b (train_rd_row)
	);

	// training enable doubles as the queue pop gate
	commit_queue u_queue (
		.clk        (clk),
		.rst        (rst),
		.push_valid (commit_valid),
		.push_data  (commit),
		.push_ready (commit_ready),
		.pop_en     (train_en),
		.pop_valid  (pop_valid),
		.pop_data   (pop_data),
		.level      (queue_level)
	);

	perceptron_dot u_dot (
		.clk          (clk),
		.rst          (rst),
		.lookup_valid (lookup_valid),
		.lookup_pc    (lookup_pc),
		.history      (history),
		.row_idx      (look_idx),
		.row          (look_row),
		.pred_valid   (pred_valid),
		.pred_taken   (pred_taken)
	);

	perceptron_trainer u_trainer (
		.clk               (clk),
		.rst               (rst),
		.pop_valid         (pop_valid),
		.pop_data          (pop_data),
		.history           (history),
		.rd_idx            (train_rd_idx),
		.rd_row            (train_rd_row),
		.we                (train_we),
		.wr_idx            (train_wr_idx),
		.wr_row            (train_wr_row),
		.retire            (retire),
		.retire_mispredict (retire_mispredict)
	);

	// full flag comes from comparing the level against the depth
	bp_apb_regs u_regs (
		.clk               (clk),
		.rst               (rst),
		.apb_req           (apb_req),
		.apb_rsp           (apb_rsp),
		.retire            (retire),
		.retire_mispredict (retire_mispredict),
		.history           (history),
		.queue_level       (queue_level),
		.queue_full        (queue_level == q_level_t'(`BP_QUEUE_DEPTH)),
		.train_en          (train_en)
	);

endmodule

//--- sim/tb_perceptron_predictor.sv
// testbench for the perceptron predictor with golden script replay, result checks and watchdog
`timescale 1ns/100ps
`include "bp_settings.svh"

module tb_perceptron_predictor import bp_pkg::*; ();

	// ==============================
	// run limits
	// ==============================
	localparam int HALF_PERIOD = 50;
	// sampling point a quarter period after the falling edge
	localparam int SETTLE = 25;
	localparam int RESET_CYCLES = 5;
	// table wipe runs one row per cycle after reset
	localparam int WIPE_CYCLES = 300;
	localparam int CYCLES_PER_LINE = 400;
	localparam int STALL_LIMIT = 100;
	localparam int APB_WAIT_LIMIT = 16;
	localparam int DRAIN_POLLS = 200;
	// falling edges from driving a lookup to seeing its pred_valid
	localparam int LOOKUP_LATENCY = 2;

	logic clk;
	logic rst;
	logic lookup_valid;
	pc_t lookup_pc;
	logic pred_valid;
	logic pred_taken;
	logic commit_valid;
	commit_t commit;
	logic commit_ready;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;

	// script and bookkeeping
	string script [$];
	bit script_ready = 1'b0;
	int cycle = 0;
	string test_name = "";
	bit in_test = 1'b0;
	int test_checks = 0;
	int test_errors = 0;
	int total_checks = 0;
	int total_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	// commit held on the port until the queue takes it
	bit parked = 1'b0;
	bit ready_prev = 1'b0;
	int stall = 0;
	// commit_ready seen at the same instant as the last apb read data
	bit ready_at_read = 1'b0;
	// outstanding lookups in request order
	int look_due [$];
	bit look_exp [$];
	pc_t look_pc [$];

	perceptron_predictor uut (
		.clk          (clk),
		.rst          (rst),
		.lookup_valid (lookup_valid),
		.lookup_pc    (lookup_pc),
		.pred_valid   (pred_valid),
		.pred_taken   (pred_taken),
		.commit_valid (commit_valid),
		.commit       (commit),
		.commit_ready (commit_ready),
		.apb_req      (apb_req),
		.apb_rsp      (apb_rsp)
	);

	always #(HALF_PERIOD) clk = ~clk;

	// ==============================
	// checking helpers
	// ==============================
	task automatic check_value(input string what, input logic [31:0] actual,
			input logic [31:0] expected);
		begin
			test_checks++;
			if (actual !== expected) begin
				$display("CHECK FAILED at %0t ns: %s, got %h expected %h",
					$time, what, actual, expected);
				test_errors++;
			end
		end
	endtask

	// strip the line ending and trailing blanks
	function automatic string trim_line(input string s);
		string t;
		begin
			t = s;
			while (t.len() > 0 && (t.getc(t.len() - 1) == 8'h0A ||
					t.getc(t.len() - 1) == 8'h0D || t.getc(t.len() - 1) == 8'h20))
				t = t.substr(0, t.len() - 2);
			return t;
		end
	endfunction

	// advance to the next falling edge and settle what happened at the rising edge
	task automatic next_cycle();
		begin
			@(negedge clk);
			cycle++;
			// ready high before the edge means the parked commit went in
			if (parked) begin
				if (ready_prev) begin
					parked = 1'b0;
					commit_valid = 1'b0;
					stall = 0;
				end else begin
					stall++;
					if (stall > STALL_LIMIT) begin
						$display("commit_ready stayed low for %0d cycles, commit of pc %h dropped",
							stall, commit.pc);
						test_errors++;
						parked = 1'b0;
						commit_valid = 1'b0;
						stall = 0;
					end
				end
			end
			ready_prev = commit_ready;
			// oldest lookup result is due now
			if (look_due.size() > 0 && look_due[0] == cycle) begin
				if (!pred_valid) begin
					$display("lookup of pc %h got no pred_valid two cycles after it at %0t ns",
						look_pc[0], $time);
					test_errors++;
				end else begin
					check_value($sformatf("prediction for pc %h", look_pc[0]),
						{31'b0, pred_taken}, {31'b0, look_exp[0]});
				end
				look_due.delete(0);
				look_exp.delete(0);
				look_pc.delete(0);
			end else if (pred_valid) begin
				$display("pred_valid high at %0t ns with no lookup outstanding", $time);
				test_errors++;
			end
		end
	endtask

	// ==============================
	// bus and port operations
	// ==============================
	// setup phase, then access phase sampled mid-cycle, done at the next rising edge
	task automatic apb_transfer(input logic write, input logic [7:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int waits;
		begin
			apb_req.psel = 1'b1;
			apb_req.penable = 1'b0;
			apb_req.pwrite = write;
			apb_req.paddr = addr;
			apb_req.pwdata = wdata;
			next_cycle();
			apb_req.penable = 1'b1;
			waits = 0;
			#(SETTLE);
			while (!apb_rsp.pready && waits < APB_WAIT_LIMIT) begin
				waits++;
				next_cycle();
				#(SETTLE);
			end
			if (!apb_rsp.pready) begin
				$display("pready never rose for offset %h at %0t ns", addr, $time);
				test_errors++;
			end
			rdata = apb_rsp.prdata;
			err = apb_rsp.pslverr;
			ready_at_read = commit_ready;
			next_cycle();
			apb_req.psel = 1'b0;
			apb_req.penable = 1'b0;
			apb_req.pwrite = 1'b0;
		end
	endtask

	// a commit that meets a full queue stays parked on the port
	task automatic send_commit(input pc_t pc, input logic taken, input logic predicted);
		begin
			while (parked)
				next_cycle();
			commit.pc = pc;
			commit.taken = taken;
			commit.predicted = predicted;
			commit_valid = 1'b1;
			parked = 1'b1;
			stall = 0;
			next_cycle();
		end
	endtask

	task automatic send_lookup(input pc_t pc, input logic expected);
		begin
			lookup_valid = 1'b1;
			lookup_pc = pc;
			look_due.push_back(cycle + LOOKUP_LATENCY);
			look_exp.push_back(expected);
			look_pc.push_back(pc);
			next_cycle();
			lookup_valid = 1'b0;
		end
	endtask

	// poll status until nothing waits on the port or in the queue
	task automatic drain_queue();
		logic [31:0] status;
		logic err;
		int polls;
		begin
			polls = 0;
			status = 32'hFFFF_FFFF;
			while ((parked || status[3:0] != 4'd0) && polls < DRAIN_POLLS) begin
				apb_transfer(1'b0, `BP_REG_STATUS, 32'h0, status, err);
				polls++;
			end
			if (parked || status[3:0] != 4'd0) begin
				$display("commit queue did not drain after %0d status polls", polls);
				test_errors++;
			end
			// last pop reaches the table two cycles later
			repeat (2) next_cycle();
		end
	endtask

	task automatic finish_test();
		begin
			while (look_due.size() > 0)
				next_cycle();
			if (in_test) begin
				tests_run++;
				if (test_errors != 0)
					tests_failed++;
				$display("test %0s: %0s, %0d checks, %0d errors", test_name,
					(test_errors == 0) ? "ok" : "failed", test_checks, test_errors);
			end
			total_checks += test_checks;
			total_errors += test_errors;
			test_checks = 0;
			test_errors = 0;
		end
	endtask

	// ==============================
	// script replay
	// ==============================
	initial begin
		int fd;
		int r;
		int cnt;
		string line;
		string fields;
		logic [7:0] op;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
		logic [31:0] rd;
		logic err;
		clk = 1'b0;
		rst = 1'b1;
		lookup_valid = 1'b0;
		lookup_pc = '0;
		commit_valid = 1'b0;
		commit = '0;
		apb_req = '0;
		fd = $fopen("sim/bp_golden.txt", "r");
		if (fd == 0) begin
			$display("could not open sim/bp_golden.txt, there is no stimulus to run");
			$display("SOME TESTS FAILED");
			$finish;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				r = $fgets(line, fd);
				if (r > 0)
					script.push_back(line);
			end
			$fclose(fd);
			script_ready = 1'b1;
			repeat (RESET_CYCLES) next_cycle();
			rst = 1'b0;
			repeat (WIPE_CYCLES) next_cycle();
			for (int n = 0; n < script.size(); n++) begin
				line = trim_line(script[n]);
				if (line.len() > 0 && line.getc(0) != "#") begin
					op = line.getc(0);
					fields = (line.len() > 2) ? line.substr(2, line.len() - 1) : "";
					a = '0;
					b = '0;
					c = '0;
					d = '0;
					case (op)
						"W": begin
							cnt = $sscanf(fields, "%h %h", a, b);
							apb_transfer(1'b1, a[7:0], b, rd, err);
							check_value($sformatf("pslverr on write to %h", a[7:0]),
								{31'b0, err}, 32'h0);
						end
						"R": begin
							cnt = $sscanf(fields, "%h %h %h", a, b, c);
							apb_transfer(1'b0, a[7:0], 32'h0, rd, err);
							check_value($sformatf("read of offset %h", a[7:0]), rd, b);
							check_value($sformatf("pslverr on read of %h", a[7:0]),
								{31'b0, err}, {31'b0, c[0]});
							// ready is low exactly when the expected status says full
							if (a[7:0] == `BP_REG_STATUS)
								check_value("commit_ready while status is read",
									{31'b0, ready_at_read}, {31'b0, ~b[4]});
						end
						"C": begin
							cnt = $sscanf(fields, "%h %h %h %h", a, b, c, d);
							// repeat count is optional
							if (cnt < 4)
								d = 32'd1;
							repeat (int'(d)) send_commit(a, b[0], c[0]);
						end
						"L": begin
							cnt = $sscanf(fields, "%h %h", a, b);
							send_lookup(a, b[0]);
						end
						"D": drain_queue();
						"T": begin
							finish_test();
							test_name = fields;
							in_test = 1'b1;
						end
						default: begin
							$display("unknown opcode on golden line %0d: %0s", n + 1, line);
							test_errors++;
						end
					endcase
				end
			end
			finish_test();
			$display("tests run %0d, failed %0d, checks %0d, errors %0d",
				tests_run, tests_failed, total_checks, total_errors);
			if (tests_run > 0 && tests_failed == 0 && total_errors == 0)
				$display("ALL TESTS PASSED");
			else
				$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// ==============================
	// watchdog
	// ==============================
	initial begin
		int limit;
		wait (script_ready);
		limit = script.size() * CYCLES_PER_LINE + RESET_CYCLES + WIPE_CYCLES;
		repeat (limit) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run is stuck", limit);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- compile.f
+incdir+logic
logic/bp_pkg.sv
logic/perceptron_ram.sv
logic/commit_queue.sv
logic/perceptron_dot.sv
logic/perceptron_trainer.sv
logic/bp_apb_regs.sv
logic/perceptron_predictor.sv
sim/tb_perceptron_predictor.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the predictor testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal \
	--top-module tb_perceptron_predictor \
	-f compile.f -o tb_perceptron_predictor \
	|| { echo "verilator build failed"; exit 1; }
./obj_dir/tb_perceptron_predictor | tee /dev/stderr | grep "ALL TESTS PASSED" > /dev/null \
	&& echo "simulation result: pass" \
	|| { echo "simulation result: fail"; exit 1; }

//--- sim/bp_golden.txt
# W addr data | R addr expected [pslverr] | C pc taken predicted [repeat]
# L pc expected_taken | D (drain queue) | T test_name ; numbers in hex
T reset_state
R 00 00000000
R 04 00000000
R 08 00000000
R 0C 00000000
R 10 00000000
R 20 00000000 1
L 00001000 1
T learning
W 00 00000001
C 00001000 0 1 14
D
R 0C 00000000
R 04 00000014
R 08 00000014
L 00001000 0
L 00002000 1
T history_counters
W 04 00000000
W 08 00000000
C 00003000 1 1
C 00003000 0 1
C 00003000 1 1
C 00003000 1 0
C 00003000 0 0
C 00003000 0 1
C 00003000 1 1
C 00003000 0 1
C 00003000 1 1
C 00003000 1 0
D
R 0C 000002CB
R 04 0000000A
R 08 00000005
W 04 00000000
R 04 00000000
R 08 00000005
T back_pressure
W 00 00000000
W 04 00000000
C 00004000 1 1 8
R 10 00000018
C 00004000 1 1
R 10 00000018
W 00 00000001
D
R 04 00000009
R 10 00000000
R 0C 000097FF
T pipelined_lookups
C 00005000 0 0 10
D
R 0C 00000000
L 00001000 0
L 00002000 1
L 00001000 0
L 00002000 1
